// File: sources.f
+incdir+verification
common/rv_pkg.sv
src/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
src/execute_stage.sv
src/mem_stage.sv
src/rv_core_top.sv
verification/tb_rv_core.sv

// File: Makefile
# Verilator build and run of the five-stage core testbench
TOP = tb_rv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f -Mdir obj_dir

# the run passes only if the pass line shows up in the output
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// File: verification/tb_ref_model.svh
// reference model functions, ISA-level ALU and a one-instruction executor on the testbench state
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// op is {inst[30], funct3}, shifts use the low five bits of b
function automatic rv_pkg::xlen_t alu_ref(input logic [3:0] op, input rv_pkg::xlen_t a, b);
    case (op)
        4'b1000: return a - b;
        4'b0001: return a << b[4:0];
        4'b0010: return {31'b0, $signed(a) < $signed(b)};
        4'b0100: return a ^ b;
        4'b0101: return a >> b[4:0];
        4'b0110: return a | b;
        4'b0111: return a & b;
        default: return a + b;
    endcase
endfunction

// runs the instruction at ref_pc and returns what the core must commit for it
function automatic rv_pkg::commit_t ref_step(input rv_pkg::inst_t inst);
    rv_pkg::commit_t res;
    rv_pkg::xlen_t   a, b, imm_i, imm_s, imm_b, imm_j, addr;
    rv_pkg::addr_t   next_pc;
    a       = ref_regs[inst[19:15]];
    b       = ref_regs[inst[24:20]];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    next_pc = ref_pc + 32'd4;
    res     = '{valid: 1'b1, pc: ref_pc, rd: inst[11:7], reg_we: 1'b0, wdata: '0};
    case (rv_pkg::opcode_e'(inst[6:0]))
        rv_pkg::OPC_OP: begin
            res.reg_we = 1'b1;
            res.wdata  = alu_ref({inst[30], inst[14:12]}, a, b);
        end
        rv_pkg::OPC_OP_IMM: begin
            res.reg_we = 1'b1;
            res.wdata  = alu_ref({1'b0, inst[14:12]}, a, imm_i);   // no immediate subtract
        end
        rv_pkg::OPC_LUI: begin
            res.reg_we = 1'b1;
            res.wdata  = {inst[31:12], 12'b0};
        end
        rv_pkg::OPC_LOAD: begin
            addr       = a + imm_i;
            res.reg_we = 1'b1;
            res.wdata  = ref_dmem[addr[9:2]];
        end
        rv_pkg::OPC_STORE: begin
            addr                = a + imm_s;
            ref_dmem[addr[9:2]] = b;
        end
        rv_pkg::OPC_BRANCH: begin
            if (inst[12] ? (a != b) : (a == b))
                next_pc = ref_pc + imm_b;
        end
        rv_pkg::OPC_JAL: begin
            res.reg_we = 1'b1;
            res.wdata  = ref_pc + 32'd4;   // link value
            next_pc    = ref_pc + imm_j;
        end
        default: ref_halted = 1'b1;   // ebreak
    endcase
    if (res.reg_we && res.rd != 5'd0)
        ref_regs[res.rd] = res.wdata;
    ref_pc = next_pc;
    return res;
endfunction

`endif

// File: verification/tb_rv_core.sv
// testbench for rv_core_top with instruction memory model, program builders, checks and report
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    localparam int DMEM_WORDS  = 256;
    localparam int N_TESTS     = 6;
    localparam int PROG_MAX    = 100;   // longest program of any test
    localparam int HALT_CYCLES = 20;
    localparam int WATCHDOG_NS = (N_TESTS * PROG_MAX * 3 + N_TESTS * (8 + HALT_CYCLES)) * 40
                                 + 4000;
    localparam rv_pkg::inst_t EBREAK = 32'h0010_0073;

    logic            clk = 1'b0;
    logic            reset_i = 1'b1;
    rv_pkg::inst_t   imem_data;
    rv_pkg::addr_t   imem_addr;
    rv_pkg::commit_t commit;
    logic            halt;

    rv_pkg::inst_t   imem [256];
    int              prog_len;
    rv_pkg::xlen_t   ref_regs [32];
    rv_pkg::xlen_t   ref_dmem [DMEM_WORDS];   // persists across tests like the core's memory
    rv_pkg::addr_t   ref_pc;
    logic            ref_halted;
    rv_pkg::commit_t exp_q [$];
    int              seed = 32'hdbaf;
    int              errors = 0;
    int              tests_run = 0;
    int              tests_failed = 0;
    int              commits_checked = 0;
    // {inst[30], funct3} of add, sub, and, or, xor, slt, sll, srl
    logic [3:0]      r_ops [8] = '{4'b0000, 4'b1000, 4'b0111, 4'b0110,
                                   4'b0100, 4'b0010, 4'b0001, 4'b0101};

    `include "tb_ref_model.svh"

    always #20 clk = ~clk;

    rv_core_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) uut (
        .clk         (clk),
        .reset_i     (reset_i),
        .imem_data_i (imem_data),
        .imem_addr_o (imem_addr),
        .commit_o    (commit),
        .halt_o      (halt)
    );

    assign imem_data = imem[imem_addr[9:2]];   // combinational read port

    function automatic rv_pkg::inst_t r_type(input logic [3:0] op,
                                             input rv_pkg::reg_idx_t rd, rs1, rs2);
        return {1'b0, op[3], 5'b0, rs2, rs1, op[2:0], rd, rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::inst_t i_type(input rv_pkg::opcode_e opc, input logic [2:0] f3,
                                             input rv_pkg::reg_idx_t rd, rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_pkg::inst_t addi_inst(input rv_pkg::reg_idx_t rd, rs1,
                                                input logic [11:0] imm);
        return i_type(rv_pkg::OPC_OP_IMM, 3'b000, rd, rs1, imm);
    endfunction

    function automatic rv_pkg::inst_t lw_inst(input rv_pkg::reg_idx_t rd, rs1,
                                              input logic [11:0] imm);
        return i_type(rv_pkg::OPC_LOAD, 3'b010, rd, rs1, imm);
    endfunction

    function automatic rv_pkg::inst_t sw_inst(input rv_pkg::reg_idx_t rs2, rs1,
                                              input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic rv_pkg::inst_t b_type(input logic [2:0] f3,
                                             input rv_pkg::reg_idx_t rs1, rs2,
                                             input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::inst_t lui_inst(input rv_pkg::reg_idx_t rd,
                                               input logic [19:0] imm);
        return {imm, rd, rv_pkg::OPC_LUI};
    endfunction

    function automatic rv_pkg::inst_t j_type(input rv_pkg::reg_idx_t rd,
                                             input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
    endfunction

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic rv_pkg::reg_idx_t rand_reg();
        return 5'(1 + rand_below(8));   // x1 to x8
    endfunction

    // unused words hold addi x0 with the word index as immediate
    task automatic start_program();
        for (int i = 0; i < 256; i++)
            imem[i] = addi_inst(5'd0, 5'd0, 12'(i));
        prog_len = 0;
    endtask

    task automatic append(input rv_pkg::inst_t inst);
        imem[prog_len] = inst;
        prog_len++;
    endtask

    task automatic check_commit(input rv_pkg::commit_t got, input rv_pkg::commit_t want);
        commits_checked++;
        if (got.pc != want.pc || got.reg_we != want.reg_we) begin
            $display("mismatch at %0d ns: pc %h reg_we %b, expected pc %h reg_we %b",
                     $time, got.pc, got.reg_we, want.pc, want.reg_we);
            errors++;
        end else if (want.reg_we && (got.rd != want.rd || got.wdata != want.wdata)) begin
            $display("mismatch at %0d ns: pc %h wrote x%0d = %h, expected x%0d = %h",
                     $time, got.pc, got.rd, got.wdata, want.rd, want.wdata);
            errors++;
        end
    endtask

    task automatic check_halt(input logic halted, input rv_pkg::commit_t c);
        if (!halted) begin
            $display("mismatch at %0d ns: halt_o low after the ebreak commit", $time);
            errors++;
        end
        if (c.valid) begin
            $display("mismatch at %0d ns: commit of pc %h after the ebreak", $time, c.pc);
            errors++;
        end
    endtask

    // expected stream from the model, then reset and run the core until halt
    task automatic run_test(input string name);
        int errs_before;
        int n_exp;
        int waited;
        errs_before = errors;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        ref_pc     = '0;
        ref_halted = 1'b0;
        exp_q.delete();
        while (!ref_halted && exp_q.size() < PROG_MAX)
            exp_q.push_back(ref_step(imem[ref_pc[9:2]]));
        n_exp = exp_q.size();
        @(posedge clk);
        reset_i <= 1'b1;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!halt && waited < n_exp * 3 + 20) begin
            @(negedge clk);
            waited++;
        end
        if (!halt) begin
            $display("test %s: the core never raised halt_o", name);
            errors++;
        end else begin
            repeat (HALT_CYCLES) begin
                @(negedge clk);
                check_halt(halt, commit);
            end
            if (exp_q.size() != 0) begin
                $display("test %s: %0d expected commits never appeared", name, exp_q.size());
                errors++;
            end
        end
        tests_run++;
        if (errors != errs_before)
            tests_failed++;
        $display("test %-10s %0d instructions, %s", name, n_exp,
                 (errors == errs_before) ? "pass" : "fail");
    endtask

    // compares every valid commit with the next expected one
    always @(negedge clk) begin
        if (!reset_i && commit.valid) begin
            if (exp_q.size() == 0) begin
                $display("commit of pc %h at %0d ns was not expected", commit.pc, $time);
                errors++;
            end else begin
                check_commit(commit, exp_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        logic [2:0]       f3;
        logic [11:0]      imm12;
        rv_pkg::reg_idx_t rd;
        int               sel;
        start_program();

        // every alu operation, lui and writes to x0
        append(addi_inst(5'd1, 5'd0, 12'd1234));
        append(addi_inst(5'd2, 5'd0, -12'd77));
        append(lui_inst(5'd3, 20'habcde));
        for (int k = 0; k < 8; k++)
            append(r_type(r_ops[k], 5'(4 + k), 5'd1, 5'd2));
        for (int k = 0; k < 8; k++) begin
            f3    = r_ops[k][2:0];
            imm12 = (f3[1:0] == 2'b01) ? 12'(k + 3) : 12'hf5a ^ 12'(k * 211);
            if (k != 1)
                append(i_type(rv_pkg::OPC_OP_IMM, f3, 5'(12 + k), 5'd3, imm12));
        end
        append(addi_inst(5'd0, 5'd1, 12'd5));
        append(r_type(4'b0000, 5'd0, 5'd1, 5'd2));
        append(r_type(4'b0110, 5'd20, 5'd0, 5'd0));   // x0 must read back as zero
        append(EBREAK);
        run_test("alu");

        start_program();
        append(addi_inst(5'd1, 5'd0, 12'd5));
        append(r_type(4'b0000, 5'd2, 5'd1, 5'd1));     // distance 1
        append(addi_inst(5'd3, 5'd0, -12'd9));
        append(r_type(4'b1000, 5'd4, 5'd2, 5'd3));     // distances 2 and 1
        append(r_type(4'b0100, 5'd5, 5'd1, 5'd4));
        append(r_type(4'b0010, 5'd6, 5'd3, 5'd2));     // distance 3, via reg file bypass
        append(r_type(4'b0110, 5'd7, 5'd5, 5'd6));
        append(r_type(4'b0000, 5'd1, 5'd7, 5'd4));
        append(r_type(4'b0001, 5'd8, 5'd1, 5'd6));
        append(r_type(4'b0101, 5'd9, 5'd8, 5'd1));
        append(EBREAK);
        run_test("forwarding");

        start_program();
        append(addi_inst(5'd1, 5'd0, 12'd64));
        append(addi_inst(5'd2, 5'd0, -12'd1234));
        append(sw_inst(5'd2, 5'd1, 12'd0));
        append(lw_inst(5'd3, 5'd1, 12'd0));
        append(r_type(4'b0000, 5'd4, 5'd3, 5'd3));     // load-use
        append(sw_inst(5'd4, 5'd1, 12'd4));
        append(lw_inst(5'd5, 5'd1, 12'd4));
        append(sw_inst(5'd5, 5'd0, 12'd8));            // store data right after its load
        append(lw_inst(5'd6, 5'd1, -12'd56));
        append(b_type(3'b000, 5'd6, 5'd5, 13'd8));     // stalled branch, taken
        append(addi_inst(5'd7, 5'd0, 12'd1));
        append(addi_inst(5'd8, 5'd6, 12'd1));
        append(EBREAK);
        run_test("memory");

        start_program();
        append(addi_inst(5'd1, 5'd0, 12'd3));
        append(addi_inst(5'd2, 5'd0, 12'd3));
        append(b_type(3'b000, 5'd1, 5'd2, 13'd8));     // beq taken
        append(addi_inst(5'd3, 5'd0, 12'd111));
        append(b_type(3'b001, 5'd1, 5'd2, 13'd8));     // bne not taken
        append(addi_inst(5'd4, 5'd0, 12'd5));
        append(b_type(3'b001, 5'd4, 5'd1, 13'd12));    // bne taken
        append(addi_inst(5'd5, 5'd0, 12'd1));
        append(addi_inst(5'd5, 5'd0, 12'd2));
        append(b_type(3'b000, 5'd4, 5'd1, 13'd8));     // beq not taken
        append(j_type(5'd6, 21'd12));
        append(addi_inst(5'd7, 5'd0, 12'd7));
        append(addi_inst(5'd7, 5'd0, 12'd8));
        append(r_type(4'b0000, 5'd8, 5'd6, 5'd4));     // uses the link value
        append(j_type(5'd0, 21'd8));
        append(addi_inst(5'd9, 5'd0, 12'd9));
        append(EBREAK);
        run_test("control");

        start_program();
        append(addi_inst(5'd1, 5'd0, 12'd1));
        append(EBREAK);
        append(addi_inst(5'd2, 5'd0, 12'd2));          // must never commit
        append(addi_inst(5'd3, 5'd0, 12'd3));
        run_test("halt");

        start_program();
        for (int r = 1; r <= 8; r++)
            append(addi_inst(5'(r), 5'd0, 12'(rand_below(4096))));
        for (int k = 0; k < 16; k++)
            append(sw_inst(5'(1 + k % 8), 5'd0, 12'(k * 4)));   // every word written first
        for (int n = 0; n < 60; n++) begin
            sel = rand_below(10);
            rd  = rand_reg();
            if (sel < 4) begin
                append(r_type(r_ops[rand_below(8)], rd, rand_reg(), rand_reg()));
            end else if (sel < 6) begin
                f3    = r_ops[rand_below(8)][2:0];
                imm12 = (f3[1:0] == 2'b01) ? 12'(rand_below(32)) : 12'(rand_below(4096));
                append(i_type(rv_pkg::OPC_OP_IMM, f3, rd, rand_reg(), imm12));
            end else if (sel == 6) begin
                append(lui_inst(rd, 20'(rand_below(1 << 20))));
            end else if (sel < 9) begin
                append(lw_inst(rd, 5'd0, 12'(rand_below(16) * 4)));
            end else begin
                append(sw_inst(rand_reg(), 5'd0, 12'(rand_below(16) * 4)));
            end
        end
        append(EBREAK);
        run_test("random");

        $display("%0d tests, %0d failed, %0d commits checked, %0d errors",
                 tests_run, tests_failed, commits_checked, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/rv_core_top.sv
// five-stage core top level, stage instances and register file
`timescale 1ns/100ps
`default_nettype none

module rv_core_top #(
    parameter int DMEM_WORDS = rv_pkg::DMEM_WORDS_DEFAULT
) (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire rv_pkg::inst_t    imem_data_i,
    output rv_pkg::addr_t         imem_addr_o,
    output rv_pkg::commit_t       commit_o,
    output logic                  halt_o
);

    rv_pkg::if_id_t   if_id;
    rv_pkg::id_ex_t   id_ex;
    rv_pkg::ex_mem_t  ex_mem;
    rv_pkg::xlen_t    ex_result, load_data;
    rv_pkg::reg_idx_t rs1, rs2;
    rv_pkg::xlen_t    rs1_data, rs2_data;
    rv_pkg::addr_t    redirect_pc;
    logic             stall, redirect, fetch_halt;

    fetch_stage u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .halt_i        (fetch_halt),
        .imem_data_i   (imem_data_i),
        .imem_addr_o   (imem_addr_o),
        .if_id_o       (if_id)
    );

    decode_stage u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .if_id_i       (if_id),
        .ex_i          (id_ex),
        .ex_result_i   (ex_result),
        .mem_i         (ex_mem),
        .mem_result_i  (load_data),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .stall_o       (stall),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .halt_o        (fetch_halt),
        .id_ex_o       (id_ex)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wr_i       (commit_o),     // written straight from the commit register
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute_stage u_execute (
        .clk          (clk),
        .reset_i      (reset_i),
        .id_ex_i      (id_ex),
        .alu_result_o (ex_result),
        .ex_mem_o     (ex_mem)
    );

    mem_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_mem (
        .clk         (clk),
        .reset_i     (reset_i),
        .ex_mem_i    (ex_mem),
        .load_data_o (load_data),
        .commit_o    (commit_o),
        .halt_o      (halt_o)
    );

endmodule

`default_nettype wire

// File: src/mem_stage.sv
// data memory, writeback select and the MEM/WB commit register
`timescale 1ns/100ps
`default_nettype none

module mem_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire rv_pkg::ex_mem_t   ex_mem_i,
    output rv_pkg::xlen_t          load_data_o,
    output rv_pkg::commit_t        commit_o,
    output logic                   halt_o
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    rv_pkg::xlen_t   dmem [DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    rv_pkg::commit_t commit_q;
    logic            halt_q;

    // word address wraps at the memory depth
    assign word_idx    = IDX_W'(ex_mem_i.alu_result[31:2] % DMEM_WORDS);
    assign load_data_o = dmem[word_idx];

    always_ff @(posedge clk) begin
        if (ex_mem_i.valid && ex_mem_i.mem_we)
            dmem[word_idx] <= ex_mem_i.store_data;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            commit_q <= '0;
            halt_q   <= 1'b0;
        end else begin
            commit_q.valid  <= ex_mem_i.valid;
            commit_q.pc     <= ex_mem_i.pc;
            commit_q.rd     <= ex_mem_i.rd;
            commit_q.reg_we <= ex_mem_i.reg_we;
            commit_q.wdata  <= ex_mem_i.mem_re ? load_data_o : ex_mem_i.alu_result;
            if (ex_mem_i.valid && ex_mem_i.halt)
                halt_q <= 1'b1;   // rises with the ebreak commit
        end
    end

    assign commit_o = commit_q;
    assign halt_o   = halt_q;

    a_word_aligned: assert property (@(posedge clk) disable iff (reset_i)
        ex_mem_i.valid && (ex_mem_i.mem_re || ex_mem_i.mem_we) |->
        ex_mem_i.alu_result[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: src/execute_stage.sv
// ALU and the EX/MEM register
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire rv_pkg::id_ex_t   id_ex_i,
    output rv_pkg::xlen_t         alu_result_o,   // forwarded back to decode
    output rv_pkg::ex_mem_t       ex_mem_o
);

    rv_pkg::xlen_t   a, b;
    rv_pkg::ex_mem_t ex_mem_q;

    assign a = id_ex_i.operand_a;
    assign b = id_ex_i.operand_b;

    always_comb begin
        case (id_ex_i.alu_op)
            rv_pkg::ALU_ADD:  alu_result_o = a + b;
            rv_pkg::ALU_SUB:  alu_result_o = a - b;
            rv_pkg::ALU_AND:  alu_result_o = a & b;
            rv_pkg::ALU_OR:   alu_result_o = a | b;
            rv_pkg::ALU_XOR:  alu_result_o = a ^ b;
            rv_pkg::ALU_SLT:  alu_result_o = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLL:  alu_result_o = a << b[4:0];   // low five bits only
            rv_pkg::ALU_SRL:  alu_result_o = a >> b[4:0];
            default:          alu_result_o = b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.valid      <= id_ex_i.valid;
            ex_mem_q.pc         <= id_ex_i.pc;
            ex_mem_q.alu_result <= alu_result_o;
            ex_mem_q.store_data <= id_ex_i.store_data;
            ex_mem_q.rd         <= id_ex_i.rd;
            ex_mem_q.reg_we     <= id_ex_i.reg_we;
            ex_mem_q.mem_re     <= id_ex_i.mem_re;
            ex_mem_q.mem_we     <= id_ex_i.mem_we;
            ex_mem_q.halt       <= id_ex_i.halt;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
// instruction decode, forwarding, load-use detection, branch resolution and ID/EX register
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire rv_pkg::if_id_t   if_id_i,
    input  wire rv_pkg::id_ex_t   ex_i,
    input  wire rv_pkg::xlen_t    ex_result_i,    // live alu output of execute
    input  wire rv_pkg::ex_mem_t  mem_i,
    input  wire rv_pkg::xlen_t    mem_result_i,   // load data of the mem stage
    input  wire rv_pkg::xlen_t    rs1_data_i,
    input  wire rv_pkg::xlen_t    rs2_data_i,
    output rv_pkg::reg_idx_t      rs1_o,
    output rv_pkg::reg_idx_t      rs2_o,
    output logic                  stall_o,
    output logic                  redirect_o,
    output rv_pkg::addr_t         redirect_pc_o,
    output logic                  halt_o,
    output rv_pkg::id_ex_t        id_ex_o
);

    rv_pkg::opcode_e opcode;
    rv_pkg::xlen_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_pkg::xlen_t   rs1_val, rs2_val, mem_fwd_val;
    rv_pkg::alu_op_e funct_op;
    rv_pkg::id_ex_t  id_ex_d, id_ex_q;
    logic            uses_rs1, uses_rs2, is_ebreak, taken, halted_q;

    assign opcode = rv_pkg::opcode_e'(if_id_i.inst[6:0]);
    assign rs1_o  = if_id_i.inst[19:15];
    assign rs2_o  = if_id_i.inst[24:20];

    assign imm_i = {{20{if_id_i.inst[31]}}, if_id_i.inst[31:20]};
    assign imm_s = {{20{if_id_i.inst[31]}}, if_id_i.inst[31:25], if_id_i.inst[11:7]};
    assign imm_b = {{20{if_id_i.inst[31]}}, if_id_i.inst[7], if_id_i.inst[30:25],
                    if_id_i.inst[11:8], 1'b0};
    assign imm_u = {if_id_i.inst[31:12], 12'b0};
    assign imm_j = {{12{if_id_i.inst[31]}}, if_id_i.inst[19:12], if_id_i.inst[20],
                    if_id_i.inst[30:21], 1'b0};

    // youngest producer wins, register file covers commit
    function automatic rv_pkg::xlen_t fwd(input rv_pkg::reg_idx_t idx,
                                          input rv_pkg::xlen_t rf_data);
        if (idx != 5'd0 && ex_i.valid && ex_i.reg_we && !ex_i.mem_re && ex_i.rd == idx)
            return ex_result_i;
        if (idx != 5'd0 && mem_i.valid && mem_i.reg_we && mem_i.rd == idx)
            return mem_fwd_val;
        return rf_data;
    endfunction

    assign mem_fwd_val = mem_i.mem_re ? mem_result_i : mem_i.alu_result;

    always_comb begin
        rs1_val = fwd(rs1_o, rs1_data_i);
        rs2_val = fwd(rs2_o, rs2_data_i);
    end

    assign uses_rs1  = opcode inside {rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LOAD,
                                      rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH};
    assign uses_rs2  = opcode inside {rv_pkg::OPC_OP, rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH};
    assign is_ebreak = if_id_i.valid && opcode == rv_pkg::OPC_SYSTEM;

    // load result not ready until the mem stage
    assign stall_o = if_id_i.valid && ex_i.valid && ex_i.mem_re && ex_i.rd != 5'd0 &&
                     ((uses_rs1 && rs1_o == ex_i.rd) || (uses_rs2 && rs2_o == ex_i.rd));

    assign taken         = if_id_i.inst[12] ? (rs1_val != rs2_val) : (rs1_val == rs2_val);
    assign redirect_o    = if_id_i.valid && !stall_o &&
                           (opcode == rv_pkg::OPC_JAL || (opcode == rv_pkg::OPC_BRANCH && taken));
    assign redirect_pc_o = if_id_i.pc + ((opcode == rv_pkg::OPC_JAL) ? imm_j : imm_b);
    assign halt_o        = halted_q || is_ebreak;

    always_comb begin
        case (if_id_i.inst[14:12])
            3'b000:  funct_op = (opcode == rv_pkg::OPC_OP && if_id_i.inst[30]) ?
                                rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  funct_op = rv_pkg::ALU_SLL;
            3'b010:  funct_op = rv_pkg::ALU_SLT;
            3'b100:  funct_op = rv_pkg::ALU_XOR;
            3'b101:  funct_op = rv_pkg::ALU_SRL;
            3'b110:  funct_op = rv_pkg::ALU_OR;
            default: funct_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        id_ex_d            = '0;
        id_ex_d.valid      = if_id_i.valid && !stall_o;   // bubble on load-use
        id_ex_d.pc         = if_id_i.pc;
        id_ex_d.operand_a  = rs1_val;
        id_ex_d.operand_b  = rs2_val;
        id_ex_d.store_data = rs2_val;
        id_ex_d.alu_op     = rv_pkg::ALU_ADD;
        id_ex_d.rd         = if_id_i.inst[11:7];
        case (opcode)
            rv_pkg::OPC_OP: begin
                id_ex_d.alu_op = funct_op;
                id_ex_d.reg_we = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                id_ex_d.alu_op    = funct_op;
                id_ex_d.operand_b = imm_i;
                id_ex_d.reg_we    = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                id_ex_d.alu_op    = rv_pkg::ALU_PASS_B;
                id_ex_d.operand_b = imm_u;
                id_ex_d.reg_we    = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                id_ex_d.operand_b = imm_i;
                id_ex_d.reg_we    = 1'b1;
                id_ex_d.mem_re    = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                id_ex_d.operand_b = imm_s;
                id_ex_d.mem_we    = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                id_ex_d.alu_op    = rv_pkg::ALU_PASS_B;
                id_ex_d.operand_b = if_id_i.pc + 32'd4;   // link value
                id_ex_d.reg_we    = 1'b1;
            end
            rv_pkg::OPC_SYSTEM: id_ex_d.halt = 1'b1;
            default: ;   // branches write nothing
        endcase
        if (!id_ex_d.valid) begin
            id_ex_d.reg_we = 1'b0;
            id_ex_d.mem_re = 1'b0;
            id_ex_d.mem_we = 1'b0;
            id_ex_d.halt   = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_ex_q  <= '0;
            halted_q <= 1'b0;
        end else begin
            id_ex_q <= id_ex_d;
            if (is_ebreak && !stall_o)
                halted_q <= 1'b1;   // sticky until reset
        end
    end

    assign id_ex_o = id_ex_q;

    // the fall-through fetch behind a taken transfer never reaches decode
    a_redirect_flushes: assert property (@(posedge clk) disable iff (reset_i)
        redirect_o |=> !if_id_i.valid);

    // fetch holds the stalled instruction for the retry
    a_stall_holds: assert property (@(posedge clk) disable iff (reset_i)
        stall_o |=> $stable(if_id_i));

endmodule

`default_nettype wire

// File: decode/reg_file.sv
// 32 x 32-bit register file, two read ports and a write-first commit port
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire rv_pkg::reg_idx_t  rs1_i,
    input  wire rv_pkg::reg_idx_t  rs2_i,
    input  wire rv_pkg::commit_t   wr_i,
    output rv_pkg::xlen_t          rs1_data_o,
    output rv_pkg::xlen_t          rs2_data_o
);

    rv_pkg::xlen_t regs [1:31];   // x0 has no storage
    logic          wr_en;

    assign wr_en = wr_i.valid && wr_i.reg_we && wr_i.rd != 5'd0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_i.rd] <= wr_i.wdata;
        end
    end

    // commit in the same cycle shows through
    assign rs1_data_o = (rs1_i == 5'd0) ? '0 :
                        (wr_en && wr_i.rd == rs1_i) ? wr_i.wdata : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 :
                        (wr_en && wr_i.rd == rs2_i) ? wr_i.wdata : regs[rs2_i];

endmodule

`default_nettype wire

// File: src/fetch_stage.sv
// program counter, instruction memory address and the IF/ID register
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  wire                 clk,
    input  wire                 reset_i,
    input  wire                 stall_i,        // load-use hold
    input  wire                 redirect_i,     // taken branch or jal in decode
    input  wire rv_pkg::addr_t  redirect_pc_i,
    input  wire                 halt_i,         // ebreak seen by decode
    input  wire rv_pkg::inst_t  imem_data_i,
    output rv_pkg::addr_t       imem_addr_o,
    output rv_pkg::if_id_t      if_id_o
);

    rv_pkg::addr_t  pc_q;
    rv_pkg::if_id_t if_id_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q          <= '0;
            if_id_q.valid <= 1'b0;
        end else if (redirect_i) begin
            pc_q          <= redirect_pc_i;
            if_id_q.valid <= 1'b0;       // drop the fall-through fetch
        end else if (!stall_i) begin
            if (halt_i) begin
                if_id_q.valid <= 1'b0;   // pc frozen, nothing more enters
            end else begin
                pc_q    <= pc_q + 32'd4;
                if_id_q <= '{valid: 1'b1, pc: pc_q, inst: imem_data_i};
            end
        end
    end

    assign imem_addr_o = pc_q;
    assign if_id_o     = if_id_q;

endmodule

`default_nettype wire

// File: common/rv_pkg.sv
// shared widths, opcode and alu enums, and inter-stage pipeline structs
`default_nettype none

package rv_pkg;

    typedef logic [31:0] xlen_t;     // data word
    typedef logic [31:0] addr_t;     // byte address
    typedef logic [31:0] inst_t;     // instruction word
    typedef logic [4:0]  reg_idx_t;  // architectural register index

    parameter int DMEM_WORDS_DEFAULT = 256;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B    // lui and jal link value
    } alu_op_e;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        xlen_t    operand_a;
        xlen_t    operand_b;
        xlen_t    store_data;
        alu_op_e  alu_op;
        reg_idx_t rd;
        logic     reg_we;
        logic     mem_re;
        logic     mem_we;
        logic     halt;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        xlen_t    alu_result;   // also the memory address
        xlen_t    store_data;
        reg_idx_t rd;
        logic     reg_we;
        logic     mem_re;
        logic     mem_we;
        logic     halt;
    } ex_mem_t;

    // mem/wb register, doubles as the commit port
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        reg_idx_t rd;
        logic     reg_we;
        xlen_t    wdata;
    } commit_t;

endpackage

`default_nettype wire
